// ==== Makefile ====
# Verilator build for the pulp soc testbench

VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= tb_pulp
RTL_TOP   ?= pulp
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Iinclude rtl/pulp_pkg.sv rtl/soc_bus.sv rtl/l2_mem.sv \
		rtl/cluster_ctrl.sv rtl/pulp.sv --top-module $(RTL_TOP)

$(BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_clk_gen.sv ====
// testbench clock and reset generator: free-running clock, reset held low for a few cycles
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 40,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release a little after an edge so it never races the clock
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

// ==== dv/tb_pulp.sv ====
// pulp soc testbench: axi4-lite host traffic to l2 and cluster control with reference checks
`timescale 1ns/100ps
`include "pulp_params.svh"

module tb_pulp;

  import pulp_pkg::*;

  localparam int unsigned CYCLE_LIMIT = 2000;
  localparam int unsigned N_REF = 16;
  localparam int unsigned N_CL = `PULP_N_CLUSTERS;
  localparam lite_addr_t EVT_ADDR = `PULP_CTRL_BASE + `PULP_REG_EVT;
  localparam lite_addr_t FEN_ADDR = `PULP_CTRL_BASE + `PULP_REG_FETCH_EN;
  localparam lite_addr_t STS_ADDR = `PULP_CTRL_BASE + `PULP_REG_STATUS;

  logic       clk;
  logic       arst_n;
  lite_req_t  req;
  lite_resp_t rsp;
  cl_vec_t    cl_fetch_en;
  cl_vec_t    cl_eoc;
  cl_vec_t    cl_busy;
  cl_vec_t    cl_evt;

  int          seed = 32'hcaf8_5720;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cycles = 0;
  lite_data_t  l2_ref [N_REF];
  cl_vec_t     fetch_exp;
  cl_vec_t     evt_exp;
  logic        wr_hs;
  logic        rd_hs;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) i_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

  pulp i_pulp (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .lite_req_i    (req),
    .lite_resp_o   (rsp),
    .cl_fetch_en_o (cl_fetch_en),
    .cl_eoc_i      (cl_eoc),
    .cl_busy_i     (cl_busy),
    .cl_evt_o      (cl_evt)
  );

  assign wr_hs = req.aw_valid & rsp.aw_ready & req.w_valid & rsp.w_ready;
  assign rd_hs = req.ar_valid & rsp.ar_ready;

  task automatic report_fail(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic check_eq(input string what, input lite_data_t got, input lite_data_t exp);
    checks++;
    assert (got === exp) else report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  // expected outputs of cluster control, tracked from handshakes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_exp <= '0;
      evt_exp   <= '0;
    end else begin
      evt_exp <= '0;
      if (wr_hs && req.w_strb[0] && req.aw_addr == FEN_ADDR) begin
        fetch_exp <= req.w_data[N_CL-1:0];
      end
      if (wr_hs && req.w_strb[0] && req.aw_addr == EVT_ADDR) begin
        evt_exp <= req.w_data[N_CL-1:0];
      end
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) wr_hs |=> rsp.b_valid)
    else report_fail("b valid not one cycle after write handshake");
  assert property (@(posedge clk) disable iff (!arst_n) rd_hs |=> rsp.r_valid)
    else report_fail("r valid not one cycle after read handshake");
  assert property (@(posedge clk) disable iff (!arst_n)
    (rsp.b_valid && !req.b_ready) |=> (rsp.b_valid && $stable(rsp.b_resp)))
    else report_fail("write response changed under back-pressure");
  assert property (@(posedge clk) disable iff (!arst_n)
    (rsp.r_valid && !req.r_ready) |=>
      (rsp.r_valid && $stable(rsp.r_data) && $stable(rsp.r_resp)))
    else report_fail("read response changed under back-pressure");
  assert property (@(posedge clk) disable iff (!arst_n)
    (rsp.b_valid || rsp.r_valid) |-> !(rsp.aw_ready || rsp.w_ready || rsp.ar_ready))
    else report_fail("address accepted while a response is pending");
  assert property (@(posedge clk) disable iff (!arst_n) cl_evt == evt_exp)
    else report_fail($sformatf("cl_evt_o is %b, expected %b", cl_evt, evt_exp));
  assert property (@(posedge clk) disable iff (!arst_n) cl_fetch_en == fetch_exp)
    else report_fail($sformatf("cl_fetch_en_o is %b, expected %b", cl_fetch_en, fetch_exp));

  // host ready stalls of 0 to 3 cycles
  task automatic stall_random();
    int unsigned n;
    n = $unsigned($random(seed)) % 4;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_xact(input lite_addr_t addr, input lite_data_t data,
                            input lite_strb_t strb, output logic [1:0] resp);
    logic got;
    req.aw_addr  = addr;
    req.aw_valid = 1'b1;
    req.w_data   = data;
    req.w_strb   = strb;
    req.w_valid  = 1'b1;
    do begin
      @(negedge clk);
      got = rsp.aw_ready & rsp.w_ready;
      @(posedge clk);
    end while (!got);
    #1;
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    stall_random();
    req.b_ready = 1'b1;
    do begin
      @(negedge clk);
      got  = rsp.b_valid;
      resp = rsp.b_resp;
      @(posedge clk);
    end while (!got);
    #1 req.b_ready = 1'b0;
  endtask

  task automatic read_xact(input lite_addr_t addr, output lite_data_t data,
                           output logic [1:0] resp);
    logic got;
    req.ar_addr  = addr;
    req.ar_valid = 1'b1;
    do begin
      @(negedge clk);
      got = rsp.ar_ready;
      @(posedge clk);
    end while (!got);
    #1 req.ar_valid = 1'b0;
    stall_random();
    req.r_ready = 1'b1;
    do begin
      @(negedge clk);
      got  = rsp.r_valid;
      data = rsp.r_data;
      resp = rsp.r_resp;
      @(posedge clk);
    end while (!got);
    #1 req.r_ready = 1'b0;
  endtask

  // read back and compare data and response code
  task automatic read_check(input string what, input lite_addr_t addr,
                            input lite_data_t exp, input logic [1:0] exp_resp);
    lite_data_t data;
    logic [1:0] resp;
    read_xact(addr, data, resp);
    check_eq({what, " data"}, data, exp);
    check_eq({what, " resp"}, lite_data_t'(resp), lite_data_t'(exp_resp));
  endtask

  function automatic lite_data_t merge_strb(lite_data_t old, lite_data_t data, lite_strb_t strb);
    lite_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_l2_all(input string what);
    for (int i = 0; i < N_REF; i++) begin
      read_check(what, `PULP_L2_BASE + 4 * i, l2_ref[i], `PULP_RESP_OKAY);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles, a transaction never completed", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    lite_data_t  data;
    lite_strb_t  strb;
    logic [1:0]  resp;
    int unsigned idx;
    lite_addr_t  bad_addr [4];

    req     = '0;
    cl_eoc  = '0;
    cl_busy = '0;
    bad_addr = '{32'h0000_0000, 32'h1C00_0400, 32'h1A10_0010, 32'h2000_0000};
    @(posedge arst_n);
    @(negedge clk);
    check_eq("reset aw/w/ar ready", lite_data_t'({rsp.aw_ready, rsp.w_ready, rsp.ar_ready}), '0);
    check_eq("reset b/r valid", lite_data_t'({rsp.b_valid, rsp.r_valid}), '0);
    check_eq("reset fetch enable", lite_data_t'(cl_fetch_en), '0);
    check_eq("reset event", lite_data_t'(cl_evt), '0);
    @(posedge clk);
    #1;

    // fill the reference window, then strobed overwrites
    for (int i = 0; i < N_REF; i++) begin
      data = $random(seed);
      write_xact(`PULP_L2_BASE + 4 * i, data, 4'hf, resp);
      check_eq("l2 fill write resp", lite_data_t'(resp), lite_data_t'(`PULP_RESP_OKAY));
      l2_ref[i] = data;
    end
    for (int i = 0; i < 40; i++) begin
      idx  = $unsigned($random(seed)) % N_REF;
      data = $random(seed);
      strb = lite_strb_t'($random(seed));
      write_xact(`PULP_L2_BASE + 4 * idx, data, strb, resp);
      check_eq("l2 strobed write resp", lite_data_t'(resp), lite_data_t'(`PULP_RESP_OKAY));
      l2_ref[idx] = merge_strb(l2_ref[idx], data, strb);
    end

    // a read raised together with a write waits until the write response is taken
    for (int i = 0; i < 4; i++) begin
      idx  = $unsigned($random(seed)) % N_REF;
      data = $random(seed);
      req.ar_addr  = `PULP_L2_BASE + 4 * idx;
      req.ar_valid = 1'b1;
      write_xact(`PULP_L2_BASE + 4 * idx, data, 4'hf, resp);
      check_eq("l2 write before read resp", lite_data_t'(resp), lite_data_t'(`PULP_RESP_OKAY));
      l2_ref[idx] = data;
      read_check("l2 read after write", `PULP_L2_BASE + 4 * idx, data, `PULP_RESP_OKAY);
    end
    check_l2_all("l2 read");

    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      write_xact(FEN_ADDR, data, 4'hf, resp);
      read_check("fetch enable", FEN_ADDR, lite_data_t'(data[N_CL-1:0]), `PULP_RESP_OKAY);
    end

    // status inputs settle two cycles before the read
    for (int i = 0; i < 4; i++) begin
      cl_eoc  = cl_vec_t'($random(seed));
      cl_busy = cl_vec_t'($random(seed));
      repeat (2) begin
        @(posedge clk);
        #1;
      end
      data = '0;
      data[`PULP_STATUS_EOC_LSB +: N_CL]  = cl_eoc;
      data[`PULP_STATUS_BUSY_LSB +: N_CL] = cl_busy;
      read_check("status", STS_ADDR, data, `PULP_RESP_OKAY);
    end

    for (int i = 0; i < 4; i++) begin
      write_xact(EVT_ADDR, $random(seed), 4'hf, resp);
      check_eq("event write resp", lite_data_t'(resp), lite_data_t'(`PULP_RESP_OKAY));
    end
    read_check("event read", EVT_ADDR, '0, `PULP_RESP_OKAY);

    for (int i = 0; i < 4; i++) begin
      write_xact(bad_addr[i], $random(seed), 4'hf, resp);
      check_eq("unmapped write resp", lite_data_t'(resp), lite_data_t'(`PULP_RESP_SLVERR));
      read_check("unmapped read", bad_addr[i], '0, `PULP_RESP_SLVERR);
    end
    check_l2_all("l2 after unmapped");
    read_check("fetch enable after unmapped", FEN_ADDR, lite_data_t'(fetch_exp), `PULP_RESP_OKAY);

    repeat (2) @(posedge clk);
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== include/pulp_params.svh ====
// pulp soc parameters: bus widths, cluster count, address map and register offsets
`ifndef PULP_PARAMS_SVH
`define PULP_PARAMS_SVH

// axi4-lite host port
`define PULP_LITE_AW 32
`define PULP_LITE_DW 32

// response codes
`define PULP_RESP_OKAY   2'b00
`define PULP_RESP_SLVERR 2'b10

`define PULP_N_CLUSTERS 2

// address map, sizes in bytes
`define PULP_L2_BASE   32'h1C00_0000
`define PULP_L2_SIZE   1024
`define PULP_CTRL_BASE 32'h1A10_0000
`define PULP_CTRL_SIZE 16

// cluster control byte offsets
`define PULP_REG_FETCH_EN 32'h0
`define PULP_REG_STATUS   32'h4
`define PULP_REG_EVT      32'h8

// status register layout
`define PULP_STATUS_EOC_LSB  0
`define PULP_STATUS_BUSY_LSB 8

`endif

// ==== list.f ====
+incdir+include
rtl/pulp_pkg.sv
rtl/soc_bus.sv
rtl/l2_mem.sv
rtl/cluster_ctrl.sv
rtl/pulp.sv
dv/tb_clk_gen.sv
dv/tb_pulp.sv

// ==== rtl/cluster_ctrl.sv ====
// cluster control: fetch enable, eoc/busy status and per-cluster event pulses
`timescale 1ns/100ps
`include "pulp_params.svh"

module cluster_ctrl (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  pulp_pkg::bus_req_t   bus_req_i,
  input  logic                 sel_i,
  output pulp_pkg::lite_data_t rdata_o,
  output pulp_pkg::cl_vec_t    cl_fetch_en_o,
  input  pulp_pkg::cl_vec_t    cl_eoc_i,
  input  pulp_pkg::cl_vec_t    cl_busy_i,
  output pulp_pkg::cl_vec_t    cl_evt_o
);

  import pulp_pkg::*;

  localparam int unsigned N_CL = `PULP_N_CLUSTERS;

  localparam reg_idx_t IDX_FETCH_EN = reg_idx_t'(`PULP_REG_FETCH_EN >> 2);
  localparam reg_idx_t IDX_STATUS   = reg_idx_t'(`PULP_REG_STATUS >> 2);
  localparam reg_idx_t IDX_EVT      = reg_idx_t'(`PULP_REG_EVT >> 2);

  reg_idx_t   idx;
  logic       wr_en;
  logic       rd_en;
  lite_data_t status;
  lite_data_t rdata_d;

  cl_vec_t fetch_en_q;
  cl_vec_t eoc_q;
  cl_vec_t busy_q;
  cl_vec_t evt_q;

  assign idx   = reg_idx_t'(bus_req_i.word_off);
  // cluster bits all sit in byte 0
  assign wr_en = sel_i & bus_req_i.we & bus_req_i.strb[0];
  assign rd_en = sel_i & ~bus_req_i.we;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_en_q <= '0;
      eoc_q      <= '0;
      busy_q     <= '0;
      evt_q      <= '0;
    end else begin
      eoc_q  <= cl_eoc_i;
      busy_q <= cl_busy_i;
      // event lasts a single cycle
      evt_q  <= '0;
      if (wr_en && idx == IDX_FETCH_EN) begin
        fetch_en_q <= bus_req_i.wdata[N_CL-1:0];
      end
      if (wr_en && idx == IDX_EVT) begin
        evt_q <= bus_req_i.wdata[N_CL-1:0];
      end
    end
  end

  always_comb begin
    status = '0;
    status[`PULP_STATUS_EOC_LSB +: N_CL]  = eoc_q;
    status[`PULP_STATUS_BUSY_LSB +: N_CL] = busy_q;
    case (idx)
      IDX_FETCH_EN: rdata_d = lite_data_t'(fetch_en_q);
      IDX_STATUS:   rdata_d = status;
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_o <= rdata_d;
    end
  end

  assign cl_fetch_en_o = fetch_en_q;
  assign cl_evt_o      = evt_q;

endmodule

// ==== rtl/l2_mem.sv ====
// l2 scratch memory: word-addressed, byte-strobe writes, registered read
`timescale 1ns/100ps
`include "pulp_params.svh"

module l2_mem (
  input  logic                 clk_i,
  input  pulp_pkg::bus_req_t   bus_req_i,
  input  logic                 sel_i,
  output pulp_pkg::lite_data_t rdata_o
);

  import pulp_pkg::*;

  localparam int unsigned N_WORDS = `PULP_L2_SIZE / 4;
  localparam int unsigned N_BYTES = $bits(lite_strb_t);

  lite_data_t mem_q [N_WORDS];

  logic wr_en;
  logic rd_en;

  assign wr_en = sel_i & bus_req_i.we;
  assign rd_en = sel_i & ~bus_req_i.we;

  // only the strobed byte lanes change
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < N_BYTES; b++) begin
        if (bus_req_i.strb[b]) begin
          mem_q[bus_req_i.word_off][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // read word holds until the next selected read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_o <= mem_q[bus_req_i.word_off];
    end
  end

endmodule

// ==== rtl/pulp.sv ====
// pulp soc top: host axi4-lite port through the soc bus to l2 and cluster control
`timescale 1ns/100ps

module pulp (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  pulp_pkg::lite_req_t  lite_req_i,
  output pulp_pkg::lite_resp_t lite_resp_o,
  output pulp_pkg::cl_vec_t    cl_fetch_en_o,
  input  pulp_pkg::cl_vec_t    cl_eoc_i,
  input  pulp_pkg::cl_vec_t    cl_busy_i,
  output pulp_pkg::cl_vec_t    cl_evt_o
);

  import pulp_pkg::*;

  // shared target request, one select per window
  bus_req_t   bus_req;
  logic       l2_sel;
  logic       ctrl_sel;
  lite_data_t l2_rdata;
  lite_data_t ctrl_rdata;

  soc_bus i_soc_bus (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .lite_req_i   (lite_req_i),
    .lite_resp_o  (lite_resp_o),
    .bus_req_o    (bus_req),
    .l2_sel_o     (l2_sel),
    .ctrl_sel_o   (ctrl_sel),
    .l2_rdata_i   (l2_rdata),
    .ctrl_rdata_i (ctrl_rdata)
  );

  l2_mem i_l2_mem (
    .clk_i     (clk_i),
    .bus_req_i (bus_req),
    .sel_i     (l2_sel),
    .rdata_o   (l2_rdata)
  );

  cluster_ctrl i_cluster_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .bus_req_i     (bus_req),
    .sel_i         (ctrl_sel),
    .rdata_o       (ctrl_rdata),
    .cl_fetch_en_o (cl_fetch_en_o),
    .cl_eoc_i      (cl_eoc_i),
    .cl_busy_i     (cl_busy_i),
    .cl_evt_o      (cl_evt_o)
  );

endmodule

// ==== rtl/pulp_pkg.sv ====
// pulp soc types: axi4-lite channel structs, internal target bus and bus fsm states
`include "pulp_params.svh"

package pulp_pkg;

  typedef logic [`PULP_LITE_AW-1:0]               lite_addr_t;
  typedef logic [`PULP_LITE_DW-1:0]               lite_data_t;
  typedef logic [`PULP_LITE_DW/8-1:0]             lite_strb_t;
  typedef logic [$clog2(`PULP_L2_SIZE/4)-1:0]     l2_word_addr_t;
  typedef logic [$clog2(`PULP_CTRL_SIZE/4)-1:0]   reg_idx_t;
  typedef logic [`PULP_N_CLUSTERS-1:0]            cl_vec_t;

  // channels driven by the host
  typedef struct packed {
    lite_addr_t aw_addr;
    logic       aw_valid;
    lite_data_t w_data;
    lite_strb_t w_strb;
    logic       w_valid;
    logic       b_ready;
    lite_addr_t ar_addr;
    logic       ar_valid;
    logic       r_ready;
  } lite_req_t;

  // channels driven by the soc
  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic [1:0] b_resp;
    logic       b_valid;
    logic       ar_ready;
    lite_data_t r_data;
    logic [1:0] r_resp;
    logic       r_valid;
  } lite_resp_t;

  // request to the targets, word offset is local to the window
  typedef struct packed {
    logic          we;
    l2_word_addr_t word_off;
    lite_data_t    wdata;
    lite_strb_t    strb;
  } bus_req_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_RESP
  } bus_state_e;

endpackage

// ==== rtl/soc_bus.sv ====
// soc bus: axi4-lite slave with address decode to l2 and cluster control windows
`timescale 1ns/100ps
`include "pulp_params.svh"

module soc_bus (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  pulp_pkg::lite_req_t  lite_req_i,
  output pulp_pkg::lite_resp_t lite_resp_o,
  output pulp_pkg::bus_req_t   bus_req_o,
  output logic                 l2_sel_o,
  output logic                 ctrl_sel_o,
  input  pulp_pkg::lite_data_t l2_rdata_i,
  input  pulp_pkg::lite_data_t ctrl_rdata_i
);

  import pulp_pkg::*;

  localparam lite_addr_t L2_BASE   = lite_addr_t'(`PULP_L2_BASE);
  localparam lite_addr_t L2_SIZE   = lite_addr_t'(`PULP_L2_SIZE);
  localparam lite_addr_t CTRL_BASE = lite_addr_t'(`PULP_CTRL_BASE);
  localparam lite_addr_t CTRL_SIZE = lite_addr_t'(`PULP_CTRL_SIZE);

  bus_state_e state_q, state_d;

  logic       wr_go;
  logic       rd_go;
  lite_addr_t addr;
  lite_addr_t l2_off;
  lite_addr_t ctrl_off;
  logic       l2_hit;
  logic       ctrl_hit;

  // target of the access in flight
  logic l2_hit_q;
  logic err_q;

  // one transaction at a time, writes win over a pending read
  assign wr_go = (state_q == IDLE) & lite_req_i.aw_valid & lite_req_i.w_valid;
  assign rd_go = (state_q == IDLE) & lite_req_i.ar_valid & ~wr_go;

  assign addr = wr_go ? lite_req_i.aw_addr : lite_req_i.ar_addr;

  // offsets wrap below the base, so one compare covers both bounds
  assign l2_off   = addr - L2_BASE;
  assign ctrl_off = addr - CTRL_BASE;
  assign l2_hit   = (l2_off < L2_SIZE);
  assign ctrl_hit = (ctrl_off < CTRL_SIZE);

  assign l2_sel_o   = (wr_go | rd_go) & l2_hit;
  assign ctrl_sel_o = (wr_go | rd_go) & ctrl_hit;

  always_comb begin
    bus_req_o.we    = wr_go;
    bus_req_o.wdata = lite_req_i.w_data;
    bus_req_o.strb  = lite_req_i.w_strb;
    if (l2_hit) begin
      bus_req_o.word_off = l2_word_addr_t'(l2_off >> 2);
    end else begin
      bus_req_o.word_off = l2_word_addr_t'(ctrl_off >> 2);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (wr_go) begin
          state_d = WRITE_RESP;
        end else if (rd_go) begin
          state_d = READ_RESP;
        end
      end
      WRITE_RESP: begin
        if (lite_req_i.b_ready) begin
          state_d = IDLE;
        end
      end
      READ_RESP: begin
        if (lite_req_i.r_ready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      l2_hit_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_go | rd_go) begin
        l2_hit_q <= l2_hit;
        err_q    <= ~(l2_hit | ctrl_hit);
      end
    end
  end

  // handshake readies, response held until the host takes it
  always_comb begin
    lite_resp_o.aw_ready = wr_go;
    lite_resp_o.w_ready  = wr_go;
    lite_resp_o.ar_ready = rd_go;
    lite_resp_o.b_valid  = (state_q == WRITE_RESP);
    lite_resp_o.r_valid  = (state_q == READ_RESP);
    lite_resp_o.b_resp   = err_q ? `PULP_RESP_SLVERR : `PULP_RESP_OKAY;
    lite_resp_o.r_resp   = err_q ? `PULP_RESP_SLVERR : `PULP_RESP_OKAY;
    if (err_q) begin
      lite_resp_o.r_data = '0;
    end else if (l2_hit_q) begin
      lite_resp_o.r_data = l2_rdata_i;
    end else begin
      lite_resp_o.r_data = ctrl_rdata_i;
    end
  end

endmodule
